/* source/starforce_pkg.sv */
// shared constants and types for the star force glue logic
// everything runs on clk_74a, bridge writes are single cycle with no ack
// bridge addresses are full 32-bit word matches

package starforce_pkg;

    //////////////////////////////
    // bridge register map
    //////////////////////////////

    localparam logic [31:0] ADDR_LIVES          = 32'h2000_0000;
    localparam logic [31:0] ADDR_DIFFICULTY     = 32'h3000_0000;
    localparam logic [31:0] ADDR_BONUS          = 32'h4000_0000;
    localparam logic [31:0] ADDR_DEMO_SOUNDS    = 32'h5000_0000;
    localparam logic [31:0] ADDR_RESET_TOGGLE   = 32'h8000_0000;
    localparam logic [31:0] ADDR_ADAPTER_ENABLE = 32'hF200_0000;

    // dip field widths
    localparam int LIVES_W      = 2;
    localparam int DIFFICULTY_W = 3;
    localparam int BONUS_W      = 3;

    //////////////////////////////
    // snac adapter
    //////////////////////////////

    // controller type reported by the adapter
    localparam logic [4:0] SNAC_TYPE_NONE     = 5'h00;
    localparam logic [4:0] SNAC_TYPE_ANALOG_A = 5'h12;
    localparam logic [4:0] SNAC_TYPE_ANALOG_B = 5'h13;

    // stick range 0x00..0xff, idle near 0x7f
    localparam logic [7:0] STICK_LOW  = 8'h40;
    localparam logic [7:0] STICK_HIGH = 8'hC0;

    //////////////////////////////
    // packed types
    //////////////////////////////

    typedef struct packed {
        logic [LIVES_W-1:0]      lives;
        logic [DIFFICULTY_W-1:0] difficulty;
        logic [BONUS_W-1:0]      bonus;
        logic                    demo_sounds;
    } game_settings_t;

    // stick fields come from joy[7:0] and joy[15:8]
    typedef struct packed {
        logic [15:0] btn;
        logic [7:0]  stick_x;
        logic [7:0]  stick_y;
    } snac_pad_t;

    // rgb444 has red in the top nibble
    typedef struct packed {
        logic        hblank;
        logic        vblank;
        logic        hsync;
        logic        vsync;
        logic [11:0] rgb444;
    } core_video_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } video_out_t;

    // bit order the game cpu expects, up is the msb
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic fire;
        logic start;
        logic coin;
    } arcade_controls_t;

endpackage

/* source/core_control.sv */
// bridge write decode, dip word and game reset generation
// settings reach game_dipsw one cycle after the write
// a reset toggle holds game_reset for RESET_HOLD_CYCLES, toggles during the hold are lost

module core_control #(
    parameter int RESET_HOLD_CYCLES = 2_097_151
) (
    input  logic        clk_74a,
    input  logic        reset,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_addr,
    input  logic [31:0] bridge_wr_data,
    input  logic        dataslot_requestwrite,
    input  logic        dataslot_allcomplete,
    output logic        snac_enable,
    output logic [15:0] game_dipsw,
    output logic        game_reset
);
    import starforce_pkg::*;

    localparam int HOLD_W = $clog2(RESET_HOLD_CYCLES + 1);

    game_settings_t settings;
    logic [15:0]    dips;
    logic           reset_toggle;
    logic           toggle_seen;
    logic           download_active;
    logic           manual_reset;
    logic [HOLD_W-1:0] hold_count;
    logic           hold_start;

    //////////////////////////////
    // bridge write decode
    //////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            settings     <= '0;
            snac_enable  <= 1'b0;
            reset_toggle <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                ADDR_LIVES:          settings.lives       <= bridge_wr_data[LIVES_W-1:0];
                ADDR_DIFFICULTY:     settings.difficulty  <= bridge_wr_data[DIFFICULTY_W-1:0];
                ADDR_BONUS:          settings.bonus       <= bridge_wr_data[BONUS_W-1:0];
                ADDR_DEMO_SOUNDS:    settings.demo_sounds <= bridge_wr_data[0];
                ADDR_ADAPTER_ENABLE: snac_enable          <= bridge_wr_data[0];
                // data is ignored, any write flips it
                ADDR_RESET_TOGGLE:   reset_toggle         <= ~reset_toggle;
                default: ;
            endcase
        end
    end

    // dip layout from high to low bits
    assign dips = {settings.demo_sounds, 1'b0, settings.lives, 6'b0,
                   settings.difficulty, settings.bonus};

    // game wants the bytes the other way round
    assign game_dipsw = {dips[7:0], dips[15:8]};

    //////////////////////////////
    // rom download tracking
    //////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            download_active <= 1'b0;
        end else if (dataslot_requestwrite) begin
            download_active <= 1'b1;
        end else if (dataslot_allcomplete) begin
            download_active <= 1'b0;
        end
    end

    //////////////////////////////
    // manual reset stretch
    //////////////////////////////

    // toggle change, not level, starts the hold
    assign hold_start = (reset_toggle != toggle_seen) && !manual_reset;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            toggle_seen  <= 1'b0;
            manual_reset <= 1'b0;
            hold_count   <= '0;
        end else begin
            toggle_seen <= reset_toggle;
            if (hold_start) begin
                manual_reset <= 1'b1;
                hold_count   <= HOLD_W'(RESET_HOLD_CYCLES - 1);
            end else if (manual_reset) begin
                // last count drops the hold
                if (hold_count == '0) begin
                    manual_reset <= 1'b0;
                end else begin
                    hold_count <= hold_count - 1'b1;
                end
            end
        end
    end

    // any of the three sources keeps the game in reset
    assign game_reset = reset | download_active | manual_reset;

endmodule

/* source/player_input_router.sv */
// routes pocket pads or snac adapter pads to player 1 and player 2
// fixed 2 cycle latency, stage one thresholds, stage two selects
// snac_type and snac_assignment are assumed to come from the same clock domain

module player_input_router (
    input  logic                    clk_74a,
    input  logic                    reset,
    input  logic                    snac_enable,
    input  logic [15:0]             cont1_key,
    input  logic [15:0]             cont2_key,
    input  starforce_pkg::snac_pad_t snac_p1,
    input  starforce_pkg::snac_pad_t snac_p2,
    input  logic [4:0]              snac_type,
    input  logic [1:0]              snac_assignment,
    output logic [15:0]             p1_controls,
    output logic [15:0]             p2_controls
);
    import starforce_pkg::*;

    logic        snac_is_analog;
    logic        passthrough;

    // stage one
    logic [15:0] snac1_eff_q;
    logic [15:0] snac2_eff_q;
    logic [15:0] snac1_raw_q;
    logic [15:0] cont1_q;
    logic [15:0] cont2_q;
    logic        passthrough_q;
    logic [1:0]  assignment_q;

    // buttons, with the dpad taken from the stick on analog pads
    function automatic logic [15:0] effective_word(input snac_pad_t pad, input logic analog);
        logic [15:0] word;
        word = pad.btn;
        if (analog) begin
            word[0] = pad.stick_y < STICK_LOW;
            word[1] = pad.stick_y > STICK_HIGH;
            word[2] = pad.stick_x < STICK_LOW;
            word[3] = pad.stick_x > STICK_HIGH;
        end
        return word;
    endfunction

    assign snac_is_analog = (snac_type == SNAC_TYPE_ANALOG_A) ||
                            (snac_type == SNAC_TYPE_ANALOG_B);

    // adapter off or no pad plugged in
    assign passthrough = !snac_enable || (snac_type == SNAC_TYPE_NONE);

    //////////////////////////////
    // stage one, thresholds
    //////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            snac1_eff_q   <= '0;
            snac2_eff_q   <= '0;
            snac1_raw_q   <= '0;
            cont1_q       <= '0;
            cont2_q       <= '0;
            passthrough_q <= 1'b1;
            assignment_q  <= 2'd0;
        end else begin
            snac1_eff_q   <= effective_word(snac_p1, snac_is_analog);
            snac2_eff_q   <= effective_word(snac_p2, snac_is_analog);
            // mode 1 hands p2 the untouched buttons
            snac1_raw_q   <= snac_p1.btn;
            cont1_q       <= cont1_key;
            cont2_q       <= cont2_key;
            passthrough_q <= passthrough;
            assignment_q  <= snac_assignment;
        end
    end

    //////////////////////////////
    // stage two, player select
    //////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_controls <= '0;
            p2_controls <= '0;
        end else if (passthrough_q) begin
            p1_controls <= cont1_q;
            p2_controls <= cont2_q;
        end else begin
            case (assignment_q)
                // snac1 is p1, pocket pad is p2
                2'd0: begin
                    p1_controls <= snac1_eff_q;
                    p2_controls <= cont1_q;
                end
                // pocket pad is p1, snac1 is p2
                2'd1: begin
                    p1_controls <= cont1_q;
                    p2_controls <= snac1_raw_q;
                end
                // both from the adapter
                2'd2: begin
                    p1_controls <= snac1_eff_q;
                    p2_controls <= snac2_eff_q;
                end
                // adapter pads swapped
                default: begin
                    p1_controls <= snac2_eff_q;
                    p2_controls <= snac1_eff_q;
                end
            endcase
        end
    end

endmodule

/* source/coin_pulse_stretcher.sv */
// stretches a coin button release into a long pulse
// the game cpu polls slowly, so a short press would be missed
// releases while the pulse runs do not restart it

module coin_pulse_stretcher #(
    parameter int COIN_PULSE_CYCLES = 1_048_575
) (
    input  logic clk_74a,
    input  logic reset,
    input  logic coin_button,
    output logic coin_pulse
);

    localparam int CNT_W = $clog2(COIN_PULSE_CYCLES + 1);

    logic             coin_prev;
    logic [CNT_W-1:0] pulse_count;
    logic             release_edge;

    // 1 to 0 on the button
    assign release_edge = coin_prev && !coin_button;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            coin_prev   <= 1'b0;
            pulse_count <= '0;
        end else begin
            coin_prev <= coin_button;
            if (pulse_count != '0) begin
                pulse_count <= pulse_count - 1'b1;
            end else if (release_edge) begin
                pulse_count <= CNT_W'(COIN_PULSE_CYCLES);
            end
        end
    end

    // high while counting down
    assign coin_pulse = (pulse_count != '0);

endmodule

/* source/video_formatter.sv */
// 12-bit core colour to 24-bit rgb for the scaler, one cycle latency
// rgb is forced to zero outside the active area
// hs and vs are single cycle pulses on the rising edge of the core sync

module video_formatter (
    input  logic                       clk_74a,
    input  logic                       reset,
    input  starforce_pkg::core_video_t core_video,
    output starforce_pkg::video_out_t  video_out
);

    logic active;
    logic hsync_prev;
    logic vsync_prev;

    assign active = !(core_video.hblank || core_video.vblank);

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            video_out  <= '0;
            hsync_prev <= 1'b0;
            vsync_prev <= 1'b0;
        end else begin
            video_out.de <= active;
            // nibble copied into both halves of each byte
            if (active) begin
                video_out.rgb <= {{2{core_video.rgb444[11:8]}},
                                  {2{core_video.rgb444[7:4]}},
                                  {2{core_video.rgb444[3:0]}}};
            end else begin
                video_out.rgb <= '0;
            end

            // rising edge only
            video_out.hs <= core_video.hsync && !hsync_prev;
            video_out.vs <= core_video.vsync && !vsync_prev;
            hsync_prev   <= core_video.hsync;
            vsync_prev   <= core_video.vsync;
        end
    end

endmodule

/* source/starforce_glue_top.sv */
// glue logic around the star force core, all on clk_74a
// core video and adapter pad state arrive as inputs
// hold lengths are parameters, shorten them for simulation

module starforce_glue_top #(
    parameter int RESET_HOLD_CYCLES = 2_097_151,
    parameter int COIN_PULSE_CYCLES = 1_048_575
) (
    input  logic                            clk_74a,
    input  logic                            reset,
    input  logic                            bridge_wr,
    input  logic [31:0]                     bridge_addr,
    input  logic [31:0]                     bridge_wr_data,
    input  logic                            dataslot_requestwrite,
    input  logic                            dataslot_allcomplete,
    input  logic [15:0]                     cont1_key,
    input  logic [15:0]                     cont2_key,
    input  starforce_pkg::snac_pad_t        snac_p1,
    input  starforce_pkg::snac_pad_t        snac_p2,
    input  logic [4:0]                      snac_type,
    input  logic [1:0]                      snac_assignment,
    input  starforce_pkg::core_video_t      core_video,
    output logic                            game_reset,
    output logic [15:0]                     game_dipsw,
    output starforce_pkg::arcade_controls_t game_controls,
    output logic [15:0]                     p2_controls,
    output starforce_pkg::video_out_t       video_out
);

    logic        snac_enable;
    logic [15:0] p1_controls;
    logic        coin_pulse;

    //////////////////////////////
    // settings and reset
    //////////////////////////////

    core_control #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) control0 (
        .clk_74a              (clk_74a),
        .reset                (reset),
        .bridge_wr            (bridge_wr),
        .bridge_addr          (bridge_addr),
        .bridge_wr_data       (bridge_wr_data),
        .dataslot_requestwrite(dataslot_requestwrite),
        .dataslot_allcomplete (dataslot_allcomplete),
        .snac_enable          (snac_enable),
        .game_dipsw           (game_dipsw),
        .game_reset           (game_reset)
    );

    //////////////////////////////
    // controls
    //////////////////////////////

    player_input_router router0 (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .snac_enable    (snac_enable),
        .cont1_key      (cont1_key),
        .cont2_key      (cont2_key),
        .snac_p1        (snac_p1),
        .snac_p2        (snac_p2),
        .snac_type      (snac_type),
        .snac_assignment(snac_assignment),
        .p1_controls    (p1_controls),
        .p2_controls    (p2_controls)
    );

    // select button acts as coin
    coin_pulse_stretcher #(
        .COIN_PULSE_CYCLES(COIN_PULSE_CYCLES)
    ) coin0 (
        .clk_74a    (clk_74a),
        .reset      (reset),
        .coin_button(p1_controls[14]),
        .coin_pulse (coin_pulse)
    );

    // dpad, face a as fire, start
    assign game_controls = '{
        up:    p1_controls[0],
        down:  p1_controls[1],
        left:  p1_controls[2],
        right: p1_controls[3],
        fire:  p1_controls[4],
        start: p1_controls[15],
        coin:  coin_pulse
    };

    //////////////////////////////
    // video
    //////////////////////////////

    video_formatter video0 (
        .clk_74a   (clk_74a),
        .reset     (reset),
        .core_video(core_video),
        .video_out (video_out)
    );

endmodule

/* dv/starforce_assert.sv */
// video and reset rules, bound onto the glue top level
// checked on every rising clk_74a edge

module starforce_assert (
    input logic                      clk_74a,
    input logic                      reset,
    input logic                      game_reset,
    input starforce_pkg::video_out_t video_out
);
    timeunit 1ns;
    timeprecision 100ps;

    // no colour outside the active area
    rgb_blanked: assert property (@(posedge clk_74a) disable iff (reset)
        !video_out.de |-> (video_out.rgb == 24'h0))
        else $error("rgb is not zero while de is low");

    // sync strobes are single cycle
    hs_single: assert property (@(posedge clk_74a) disable iff (reset)
        video_out.hs |=> !video_out.hs)
        else $error("hs stayed high for two cycles");

    vs_single: assert property (@(posedge clk_74a) disable iff (reset)
        video_out.vs |=> !video_out.vs)
        else $error("vs stayed high for two cycles");

    // host reset always reaches the game
    reset_reaches_game: assert property (@(posedge clk_74a)
        reset |-> game_reset)
        else $error("game_reset low while reset is high");

endmodule

bind starforce_glue_top starforce_assert assert0 (
    .clk_74a   (clk_74a),
    .reset     (reset),
    .game_reset(game_reset),
    .video_out (video_out)
);

/* dv/starforce_tb.sv */
// table driven testbench for the star force glue top level
// hold lengths shortened to 16 and 8 cycles
// inputs change on the falling edge and outputs are sampled there too
// the run stops at the first wrong value

module starforce_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import starforce_pkg::*;

    localparam int RESET_HOLD_CYCLES = 16;
    localparam int COIN_PULSE_CYCLES = 8;
    localparam int RESET_CYCLES      = 10;
    localparam int PAD_SAMPLES       = 4;

    typedef enum int {
        KIND_DIP,
        KIND_TOGGLE,
        KIND_DOWNLOAD,
        KIND_ROUTE,
        KIND_STICK,
        KIND_COIN,
        KIND_VIDEO
    } kind_e;

    // dut inputs
    logic             clk_74a = 1'b0;
    logic             reset;
    logic             bridge_wr;
    logic [31:0]      bridge_addr;
    logic [31:0]      bridge_wr_data;
    logic             dataslot_requestwrite;
    logic             dataslot_allcomplete;
    logic [15:0]      cont1_key;
    logic [15:0]      cont2_key;
    snac_pad_t        snac_p1;
    snac_pad_t        snac_p2;
    logic [4:0]       snac_type;
    logic [1:0]       snac_assignment;
    core_video_t      core_video;

    // dut outputs
    logic             game_reset;
    logic [15:0]      game_dipsw;
    arcade_controls_t game_controls;
    logic [15:0]      p2_controls;
    video_out_t       video_out;

    // stimulus table, one row per index
    string       names[$];
    kind_e       kinds[$];
    logic [31:0] arg_a[$];
    logic [31:0] arg_b[$];
    logic [31:0] expects[$];
    int          costs[$];

    int seed;
    int cycle_count = 0;
    int cycle_limit = 32'h7fff_ffff;

    // reference state for the dip word and the sync edges
    logic [1:0] m_lives;
    logic [2:0] m_difficulty;
    logic [2:0] m_bonus;
    logic       m_demo;
    logic       m_hsync_prev;
    logic       m_vsync_prev;

    starforce_glue_top #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES),
        .COIN_PULSE_CYCLES(COIN_PULSE_CYCLES)
    ) dut0 (
        .clk_74a              (clk_74a),
        .reset                (reset),
        .bridge_wr            (bridge_wr),
        .bridge_addr          (bridge_addr),
        .bridge_wr_data       (bridge_wr_data),
        .dataslot_requestwrite(dataslot_requestwrite),
        .dataslot_allcomplete (dataslot_allcomplete),
        .cont1_key            (cont1_key),
        .cont2_key            (cont2_key),
        .snac_p1              (snac_p1),
        .snac_p2              (snac_p2),
        .snac_type            (snac_type),
        .snac_assignment      (snac_assignment),
        .core_video           (core_video),
        .game_reset           (game_reset),
        .game_dipsw           (game_dipsw),
        .game_controls        (game_controls),
        .p2_controls          (p2_controls),
        .video_out            (video_out)
    );

    // 4 ns period
    always #2 clk_74a = ~clk_74a;

    //////////////////////////////
    // reporting
    //////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    // hang guard
    always @(posedge clk_74a) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // dip layout, then the two bytes swapped
    function automatic logic [15:0] expected_dipsw();
        logic [15:0] w;
        w = {m_demo, 1'b0, m_lives, 6'b0, m_difficulty, m_bonus};
        return {w[7:0], w[15:8]};
    endfunction

    // analog pads take the dpad from the stick
    function automatic logic [15:0] snac_word(input snac_pad_t pad, input logic analog);
        logic [15:0] w;
        w = pad.btn;
        if (analog) begin
            w[3:0] = {pad.stick_x > STICK_HIGH, pad.stick_x < STICK_LOW,
                      pad.stick_y > STICK_HIGH, pad.stick_y < STICK_LOW};
        end
        return w;
    endfunction

    task automatic route_players(input logic [1:0] mode, input logic en,
                                 input logic [4:0] ptype, output logic [15:0] e1,
                                 output logic [15:0] e2);
        logic analog;
        analog = (ptype == SNAC_TYPE_ANALOG_A) || (ptype == SNAC_TYPE_ANALOG_B);
        e1 = cont1_key;
        e2 = cont2_key;
        if (en && ptype != SNAC_TYPE_NONE) begin
            case (mode)
                2'd0: begin
                    e1 = snac_word(snac_p1, analog);
                    e2 = cont1_key;
                end
                2'd1: begin
                    e1 = cont1_key;
                    e2 = snac_p1.btn;
                end
                2'd2: begin
                    e1 = snac_word(snac_p1, analog);
                    e2 = snac_word(snac_p2, analog);
                end
                default: begin
                    e1 = snac_word(snac_p2, analog);
                    e2 = snac_word(snac_p1, analog);
                end
            endcase
        end
    endtask

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    task automatic step(input int n);
        repeat (n) @(negedge clk_74a);
    endtask

    // single cycle write, setting visible on return
    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        step(1);
        bridge_wr = 1'b0;
    endtask

    task automatic add_entry(input string name, input kind_e kind, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] exp, input int cost);
        names.push_back(name);
        kinds.push_back(kind);
        arg_a.push_back(a);
        arg_b.push_back(b);
        expects.push_back(exp);
        costs.push_back(cost);
    endtask

    task automatic build_table();
        add_entry("dip_lives", KIND_DIP, ADDR_LIVES, 0, 0, 2);
        add_entry("dip_difficulty", KIND_DIP, ADDR_DIFFICULTY, 0, 0, 2);
        add_entry("dip_bonus", KIND_DIP, ADDR_BONUS, 0, 0, 2);
        add_entry("dip_demo_sounds", KIND_DIP, ADDR_DEMO_SOUNDS, 0, 0, 2);
        add_entry("dip_unmapped", KIND_DIP, 32'h6000_0000, 0, 0, 2);
        add_entry("dip_lives_again", KIND_DIP, ADDR_LIVES, 0, 0, 2);
        add_entry("reset_toggle", KIND_TOGGLE, 0, 0, 0, RESET_HOLD_CYCLES + 4);
        add_entry("download", KIND_DOWNLOAD, 5, 0, 0, 10);
        // b holds the adapter enable above the controller type
        add_entry("route_mode0", KIND_ROUTE, 0, {26'b0, 1'b1, SNAC_TYPE_ANALOG_A}, 0, 10);
        add_entry("route_mode1", KIND_ROUTE, 1, {26'b0, 1'b1, SNAC_TYPE_ANALOG_B}, 0, 10);
        add_entry("route_mode2", KIND_ROUTE, 2, {26'b0, 1'b1, 5'h05}, 0, 10);
        add_entry("route_mode3", KIND_ROUTE, 3, {26'b0, 1'b1, SNAC_TYPE_ANALOG_B}, 0, 10);
        add_entry("route_disabled", KIND_ROUTE, 2, {26'b0, 1'b0, SNAC_TYPE_ANALOG_A}, 0, 10);
        add_entry("route_type_none", KIND_ROUTE, 3, {26'b0, 1'b1, SNAC_TYPE_NONE}, 0, 10);
        // a is stick_x, b is stick_y, expected bits are up down left right
        add_entry("stick_idle", KIND_STICK, 8'h7F, 8'h7F, 4'b0000, 4);
        add_entry("stick_up_left", KIND_STICK, 8'h3F, 8'h3F, 4'b1010, 4);
        add_entry("stick_down_right", KIND_STICK, 8'hC1, 8'hC1, 4'b0101, 4);
        add_entry("stick_at_low", KIND_STICK, 8'h40, 8'h40, 4'b0000, 4);
        add_entry("stick_at_high", KIND_STICK, 8'hC0, 8'hC0, 4'b0000, 4);
        add_entry("stick_up_right", KIND_STICK, 8'hC1, 8'h3F, 4'b1001, 4);
        add_entry("coin", KIND_COIN, 0, 0, 0, COIN_PULSE_CYCLES + 24);
        add_entry("video_random", KIND_VIDEO, 48, 0, 0, 50);
    endtask

    //////////////////////////////
    // per kind runners
    //////////////////////////////

    task automatic run_dip(input string name, input logic [31:0] addr);
        logic [31:0] data;
        data = rand32();
        bridge_write(addr, data);
        case (addr)
            ADDR_LIVES:       m_lives = data[1:0];
            ADDR_DIFFICULTY:  m_difficulty = data[2:0];
            ADDR_BONUS:       m_bonus = data[2:0];
            ADDR_DEMO_SOUNDS: m_demo = data[0];
            default: ;
        endcase
        check_value(name, 32'(expected_dipsw()), 32'(game_dipsw));
    endtask

    // hold starts two cycles after the write
    task automatic run_toggle(input string name);
        bridge_write(ADDR_RESET_TOGGLE, rand32());
        check_value({name, " before hold"}, 0, 32'(game_reset));
        for (int k = 0; k < RESET_HOLD_CYCLES; k++) begin
            step(1);
            check_value($sformatf("%s hold %0d", name, k), 1, 32'(game_reset));
        end
        step(1);
        check_value({name, " after hold"}, 0, 32'(game_reset));
    endtask

    task automatic run_download(input string name, input int busy);
        dataslot_requestwrite = 1'b1;
        step(1);
        dataslot_requestwrite = 1'b0;
        check_value({name, " start"}, 1, 32'(game_reset));
        repeat (busy) begin
            step(1);
            check_value({name, " busy"}, 1, 32'(game_reset));
        end
        dataslot_allcomplete = 1'b1;
        step(1);
        dataslot_allcomplete = 1'b0;
        check_value({name, " done"}, 0, 32'(game_reset));
    endtask

    task automatic run_route(input string name, input logic [1:0] mode, input logic [5:0] b);
        logic [15:0] e1;
        logic [15:0] e2;
        bridge_write(ADDR_ADAPTER_ENABLE, 32'(b[5]));
        repeat (PAD_SAMPLES) begin
            cont1_key       = 16'(rand32());
            cont2_key       = 16'(rand32());
            snac_p1         = rand32();
            snac_p2         = rand32();
            snac_type       = b[4:0];
            snac_assignment = mode;
            route_players(mode, b[5], b[4:0], e1, e2);
            // two stage latency
            step(2);
            check_value({name, " p2"}, 32'(e2), 32'(p2_controls));
            check_value({name, " p1"}, 32'({e1[0], e1[1], e1[2], e1[3], e1[4], e1[15]}),
                        32'({game_controls.up, game_controls.down, game_controls.left,
                             game_controls.right, game_controls.fire, game_controls.start}));
        end
    endtask

    task automatic run_stick(input string name, input logic [7:0] x, input logic [7:0] y,
                             input logic [3:0] dirs);
        bridge_write(ADDR_ADAPTER_ENABLE, 1);
        snac_type       = SNAC_TYPE_ANALOG_A;
        snac_assignment = 2'd0;
        snac_p1.btn     = 16'(rand32());
        snac_p1.stick_x = x;
        snac_p1.stick_y = y;
        step(2);
        check_value(name, 32'(dirs),
                    32'({game_controls.up, game_controls.down, game_controls.left,
                         game_controls.right}));
    endtask

    task automatic run_coin(input string name);
        // pocket keys straight through, let any old pulse run out
        snac_type = SNAC_TYPE_NONE;
        cont1_key = 16'h0000;
        step(COIN_PULSE_CYCLES + 4);
        check_value({name, " idle"}, 0, 32'(game_controls.coin));
        cont1_key[14] = 1'b1;
        step(3);
        cont1_key[14] = 1'b0;
        step(2);
        check_value({name, " before pulse"}, 0, 32'(game_controls.coin));
        for (int k = 0; k < COIN_PULSE_CYCLES; k++) begin
            step(1);
            check_value($sformatf("%s pulse %0d", name, k), 1, 32'(game_controls.coin));
            // second press and release lands inside the pulse
            if (k == 0) begin
                cont1_key[14] = 1'b1;
            end
            if (k == 2) begin
                cont1_key[14] = 1'b0;
            end
        end
        repeat (4) begin
            step(1);
            check_value({name, " after pulse"}, 0, 32'(game_controls.coin));
        end
    endtask

    task automatic run_video(input string name, input int samples);
        core_video_t cv;
        video_out_t  exp;
        repeat (samples) begin
            cv         = 16'(rand32());
            core_video = cv;
            exp.de     = !(cv.hblank || cv.vblank);
            exp.rgb    = '0;
            if (exp.de) begin
                exp.rgb = {cv.rgb444[11:8], cv.rgb444[11:8], cv.rgb444[7:4],
                           cv.rgb444[7:4], cv.rgb444[3:0], cv.rgb444[3:0]};
            end
            exp.hs       = cv.hsync && !m_hsync_prev;
            exp.vs       = cv.vsync && !m_vsync_prev;
            m_hsync_prev = cv.hsync;
            m_vsync_prev = cv.vsync;
            step(1);
            check_value(name, 32'(exp), 32'(video_out));
        end
    endtask

    task automatic run_entry(input int i);
        case (kinds[i])
            KIND_DIP:      run_dip(names[i], arg_a[i]);
            KIND_TOGGLE:   run_toggle(names[i]);
            KIND_DOWNLOAD: run_download(names[i], int'(arg_a[i]));
            KIND_ROUTE:    run_route(names[i], arg_a[i][1:0], arg_b[i][5:0]);
            KIND_STICK:    run_stick(names[i], arg_a[i][7:0], arg_b[i][7:0], expects[i][3:0]);
            KIND_COIN:     run_coin(names[i]);
            KIND_VIDEO:    run_video(names[i], int'(arg_a[i]));
            default:       fail_run($sformatf("table row %0d has no known kind", i));
        endcase
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int total;
        seed = 32'h1baf_5658;
        build_table();
        total = 0;
        foreach (costs[k]) begin
            total = total + costs[k];
        end
        cycle_limit = 2 * total + RESET_CYCLES + RESET_HOLD_CYCLES;

        reset                 = 1'b1;
        bridge_wr             = 1'b0;
        bridge_addr           = '0;
        bridge_wr_data        = '0;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        cont1_key             = '0;
        cont2_key             = '0;
        snac_p1               = '0;
        snac_p2               = '0;
        snac_type             = SNAC_TYPE_NONE;
        snac_assignment       = 2'd0;
        core_video            = '0;
        m_lives               = '0;
        m_difficulty          = '0;
        m_bonus               = '0;
        m_demo                = 1'b0;
        m_hsync_prev          = 1'b0;
        m_vsync_prev          = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk_74a);
        check_value("reset_game_reset", 1, 32'(game_reset));
        reset = 1'b0;
        step(1);
        check_value("reset_released", 0, 32'(game_reset));
        check_value("reset_dipsw", 0, 32'(game_dipsw));

        for (int i = 0; i < names.size(); i++) begin
            run_entry(i);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
source/starforce_pkg.sv
source/core_control.sv
source/player_input_router.sv
source/coin_pulse_stretcher.sv
source/video_formatter.sv
source/starforce_glue_top.sv
dv/starforce_assert.sv
dv/starforce_tb.sv

/* Makefile */
# Verilator build for the star force glue testbench

VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := starforce_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench printed the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
